// ==== logic/neuralPkg.sv ====
`default_nettype none

package neuralPkg;

	// Datapath widths
	localparam int dataWidth       = 24;
	localparam int activationWidth = 8;

	localparam int inputCount  = 15;
	localparam int neuronCount = 2;

	// Rising edges from the top-level features to the decision outputs
	localparam int latency = 4;

	typedef logic [dataWidth-1:0]       data_t;
	typedef logic [activationWidth-1:0] act_t;

	// Input 0 sits in the lowest word
	typedef data_t [inputCount-1:0] featureVec_t;

	// Clipped rectifier limits
	localparam data_t saturateLimit = 24'd4096; // A positive sum above this saturates
	localparam act_t  activationMax = 8'd255;
	localparam int    fracShift     = 5;        // Lowest sum bit kept in the output

	// One row per neuron, indexed by input number
	localparam data_t weightTable [neuronCount][inputCount] = '{
		'{
			-24'sd1,  24'sd0,   -24'sd5,
			-24'sd20, 24'sd0,   -24'sd3,
			24'sd7,   24'sd8,   -24'sd20,
			-24'sd16, -24'sd20, 24'sd17,
			24'sd1,   -24'sd9,  24'sd23
		},
		'{
			24'sd3,   -24'sd2,  24'sd11,
			24'sd4,   -24'sd7,  24'sd0,
			24'sd5,   -24'sd1,  24'sd9,
			-24'sd13, 24'sd2,   24'sd6,
			-24'sd4,  24'sd10,  -24'sd8
		}
	};

	// Bias added after the weighted sum, one per neuron
	localparam data_t biasTable [neuronCount] = '{
		24'sd5,
		-24'sd12
	};

endpackage

`default_nettype wire

// ==== logic/neuronResultIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface neuronResultIf;
	import neuralPkg::*;

	act_t  act;       // Clipped activation
	data_t rawSum;    // Registered sum, one stage ahead of act
	logic  saturated;
	logic  rectified;

	modport producer (
		output act,
		output rawSum,
		output saturated,
		output rectified
	);

	modport consumer (
		input act,
		input rawSum,
		input saturated,
		input rectified
	);

endinterface

`default_nettype wire

// ==== logic/neuronCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronCore #(
	parameter int neuronIdx = 0
) (
	input wire logic                     clk,
	input wire logic                     reset,
	input wire neuralPkg::featureVec_t   features,
	neuronResultIf.producer              result
);
	import neuralPkg::*;

	featureVec_t featReg;
	data_t       product [inputCount];
	data_t       sumNext;
	data_t       sumReg;

	act_t actNext;
	logic satNext;
	logic rectNext;

	// Stage 1 captures the inputs
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featReg <= '0;
		end
		else
		begin
			featReg <= features;
		end
	end

	// Products keep only the low 24 bits, so they wrap like the sum does
	always_comb
	begin
		for (int i = 0; i < inputCount; i++)
		begin
			product[i] = featReg[i] * weightTable[neuronIdx][i];
		end
	end

	always_comb
	begin
		sumNext = biasTable[neuronIdx];
		for (int i = 0; i < inputCount; i++)
		begin
			sumNext = sumNext + product[i];
		end
	end

	// Stage 2 holds the biased sum
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	assign result.rawSum = sumReg;

	// Clipped rectifier
	always_comb
	begin
		satNext  = 1'b0;
		rectNext = 1'b0;
		if (sumReg[dataWidth-1])
		begin
			actNext  = '0;
			rectNext = 1'b1;
		end
		else if (sumReg > saturateLimit)
		begin
			actNext = activationMax;
			satNext = 1'b1;
		end
		else
		begin
			actNext = sumReg[fracShift +: activationWidth]; // Bits 12 down to 5
		end
	end

	// Stage 3 drives the result to the decision stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result.act       <= '0;
			result.saturated <= 1'b0;
			result.rectified <= 1'b0;
		end
		else
		begin
			result.act       <= actNext;
			result.saturated <= satNext;
			result.rectified <= rectNext;
		end
	end

	satRectExclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(result.saturated && result.rectified)
	);

	satGivesMax: assert property (
		@(posedge clk) disable iff (reset)
		result.saturated |-> result.act == activationMax
	);

	rectGivesZero: assert property (
		@(posedge clk) disable iff (reset)
		result.rectified |-> result.act == '0
	);

endmodule

`default_nettype wire

// ==== logic/classDecider.sv ====
`timescale 1ns/1ps
`default_nettype none

module classDecider (
	input wire logic           clk,
	input wire logic           reset,
	neuronResultIf.consumer    resA,
	neuronResultIf.consumer    resB,
	output logic               winner,
	output neuralPkg::act_t    winAct,
	output neuralPkg::act_t    margin,
	output logic               tie,
	output logic               anySaturated
);
	import neuralPkg::*;

	logic aWins;
	act_t diffAB;
	act_t diffBA;

	// Neuron 0 keeps the win on equal activations
	assign aWins  = resA.act >= resB.act;
	assign diffAB = resA.act - resB.act;
	assign diffBA = resB.act - resA.act;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			winner       <= 1'b0;
			winAct       <= '0;
			margin       <= '0;
			tie          <= 1'b0;
			anySaturated <= 1'b0;
		end
		else
		begin
			winner       <= !aWins;
			winAct       <= aWins ? resA.act : resB.act;
			margin       <= aWins ? diffAB : diffBA; // Always the non-negative difference
			tie          <= resA.act == resB.act;
			anySaturated <= resA.saturated | resB.saturated;
		end
	end

	tieMeansNoMargin: assert property (
		@(posedge clk) disable iff (reset)
		tie |-> margin == '0
	);

	// The registered winner is at least as large as either activation it was chosen from
	winActIsMax: assert property (
		@(posedge clk) disable iff (reset)
		winAct >= $past(resA.act) && winAct >= $past(resB.act)
	);

endmodule

`default_nettype wire

// ==== logic/hiddenPairTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module hiddenPairTop (
	input wire logic                     clk,
	input wire logic                     reset,
	input wire neuralPkg::featureVec_t   features,
	output logic                         winner,
	output neuralPkg::act_t              winAct,
	output neuralPkg::act_t              margin,
	output logic                         tie,
	output logic                         anySaturated
);

	// One result bundle per hidden neuron
	neuronResultIf resA ();
	neuronResultIf resB ();

	// Both neurons see the same feature vector in the same cycle
	neuronCore #(
		.neuronIdx(0)
	) neuron0 (
		.clk      (clk),
		.reset    (reset),
		.features (features),
		.result   (resA)
	);

	neuronCore #(
		.neuronIdx(1)
	) neuron1 (
		.clk      (clk),
		.reset    (reset),
		.features (features),
		.result   (resB)
	);

	classDecider decider (
		.clk          (clk),
		.reset        (reset),
		.resA         (resA),
		.resB         (resB),
		.winner       (winner),
		.winAct       (winAct),
		.margin       (margin),
		.tie          (tie),
		.anySaturated (anySaturated)
	);

endmodule

`default_nettype wire

// ==== tb/hiddenPairChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module hiddenPairChecker (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire neuralPkg::featureVec_t features,
	input wire logic [8*12-1:0]        testName,
	input wire logic                   tableValid,
	input wire logic [18:0]            tableExp,
	input wire logic                   winner,
	input wire neuralPkg::act_t        winAct,
	input wire neuralPkg::act_t        margin,
	input wire logic                   tie,
	input wire logic                   anySaturated,
	output int                         errorCount,
	output int                         checkCount
);
	import neuralPkg::*;

	typedef struct packed {
		logic winner;
		act_t winAct;
		act_t margin;
		logic tie;
		logic anySat;
	} decision_t;

	decision_t       modelPipe [latency];
	decision_t       tablePipe [latency];
	logic            tableValidPipe [latency];
	logic [8*12-1:0] namePipe [latency];
	decision_t       observed;
	logic            primed = 1'b0; // Set once the first reset edge has cleared the DUT
	int              errors = 0;
	int              checks = 0;

	assign observed   = {winner, winAct, margin, tie, anySaturated};
	assign errorCount = errors;
	assign checkCount = checks;

	// Weighted sum plus bias, wrapping at 24 bits
	function automatic data_t neuronSum(input featureVec_t f, input int n);
		data_t acc;
		acc = biasTable[n];
		for (int i = 0; i < inputCount; i++)
		begin
			acc = acc + f[i] * weightTable[n][i];
		end
		return acc;
	endfunction

	function automatic logic overLimit(input data_t s);
		return !s[dataWidth-1] && s > saturateLimit;
	endfunction

	function automatic act_t clipAct(input data_t s);
		if (s[dataWidth-1])
		begin
			return '0;
		end
		if (s > saturateLimit)
		begin
			return activationMax;
		end
		return s[fracShift +: activationWidth];
	endfunction

	function automatic decision_t decide(input featureVec_t f);
		data_t     sumA;
		data_t     sumB;
		act_t      a;
		act_t      b;
		decision_t d;
		sumA     = neuronSum(f, 0);
		sumB     = neuronSum(f, 1);
		a        = clipAct(sumA);
		b        = clipAct(sumB);
		d.winner = b > a; // Neuron 0 keeps equal activations
		d.winAct = (b > a) ? b : a;
		d.margin = (b > a) ? b - a : a - b;
		d.tie    = a == b;
		d.anySat = overLimit(sumA) || overLimit(sumB);
		return d;
	endfunction

	task automatic compareField(input logic [8*12-1:0] name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Error %0s %0s: expected %0d, actual %0d", name, field, expected, actual);
		end
	endtask

	task automatic checkDecision(input string source, input decision_t expected,
		input decision_t actual, input logic [8*12-1:0] name);
		compareField(name, {source, " winner"}, 32'(expected.winner), 32'(actual.winner));
		compareField(name, {source, " winAct"}, 32'(expected.winAct), 32'(actual.winAct));
		compareField(name, {source, " margin"}, 32'(expected.margin), 32'(actual.margin));
		compareField(name, {source, " tie"}, 32'(expected.tie), 32'(actual.tie));
		compareField(name, {source, " anySaturated"}, 32'(expected.anySat),
			32'(actual.anySat));
	endtask

	// A cleared pipeline looks like zero vectors to every stage but the decision register
	always @(posedge clk)
	begin
		if (reset)
		begin
			primed <= 1'b1;
			for (int i = 0; i < latency; i++)
			begin
				modelPipe[i]      <= (i == latency - 1) ? '0 : decide('0);
				tablePipe[i]      <= '0;
				tableValidPipe[i] <= 1'b0;
				namePipe[i]       <= "reset";
			end
		end
		else
		begin
			modelPipe[0]      <= decide(features);
			tablePipe[0]      <= tableExp;
			tableValidPipe[0] <= tableValid;
			namePipe[0]       <= testName;
			for (int i = 1; i < latency; i++)
			begin
				modelPipe[i]      <= modelPipe[i-1];
				tablePipe[i]      <= tablePipe[i-1];
				tableValidPipe[i] <= tableValidPipe[i-1];
				namePipe[i]       <= namePipe[i-1];
			end
		end
	end

	always @(negedge clk)
	begin
		if (primed)
		begin
			checkDecision("model", modelPipe[latency-1], observed, namePipe[latency-1]);
			if (tableValidPipe[latency-1])
			begin
				checkDecision("table", tablePipe[latency-1], observed, namePipe[latency-1]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/hiddenPairTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hiddenPairTb;
	import neuralPkg::*;

	localparam int rowCount    = 11;
	localparam int randomCount = 200;

	logic            clk = 1'b0;
	logic            reset;
	featureVec_t     features;
	logic [8*12-1:0] testName;
	logic            tableValid;
	logic [18:0]     tableExp; // winner, winAct, margin, tie, anySaturated
	logic            winner;
	act_t            winAct;
	act_t            margin;
	logic            tie;
	logic            anySaturated;
	int              errorCount;
	int              checkCount;
	int              seed;

	logic [8*12-1:0] rowName [rowCount];
	featureVec_t     rowFeatures [rowCount];
	logic [18:0]     rowExp [rowCount];

	always
	begin
		#50 clk = ~clk;
	end

	hiddenPairTop DUT (
		.clk          (clk),
		.reset        (reset),
		.features     (features),
		.winner       (winner),
		.winAct       (winAct),
		.margin       (margin),
		.tie          (tie),
		.anySaturated (anySaturated)
	);

	hiddenPairChecker resultCheck (
		.clk          (clk),
		.reset        (reset),
		.features     (features),
		.testName     (testName),
		.tableValid   (tableValid),
		.tableExp     (tableExp),
		.winner       (winner),
		.winAct       (winAct),
		.margin       (margin),
		.tie          (tie),
		.anySaturated (anySaturated),
		.errorCount   (errorCount),
		.checkCount   (checkCount)
	);

	// Rows drive at most two inputs; single-input rows repeat the same index
	task automatic setRow(input int row, input logic [8*12-1:0] name, input int inA,
		input data_t valA, input int inB, input data_t valB, input logic expWinner,
		input act_t expAct, input act_t expMargin, input logic expTie, input logic expSat);
		rowName[row]          = name;
		rowFeatures[row]      = '0;
		rowFeatures[row][inA] = valA;
		rowFeatures[row][inB] = valB;
		rowExp[row]           = {expWinner, expAct, expMargin, expTie, expSat};
	endtask

	task automatic driveRandom(input int n);
		data_t word;
		for (int k = 0; k < inputCount; k++)
		begin
			word = data_t'($random(seed));
			if (n % 2 == 0)
			begin
				word = word & 24'h0000ff;
			end
			features[k] = word;
		end
		testName   = (n % 2 == 0) ? "rand8" : "rand24";
		tableValid = 1'b0;
	endtask

	initial
	begin
		seed       = 32'h5c0e656d;
		reset      = 1'b1;
		features   = '0;
		testName   = "reset";
		tableValid = 1'b0;
		tableExp   = '0;

		setRow(0, "zeros", 0, 24'd0, 0, 24'd0, 1'b0, 8'd0, 8'd0, 1'b1, 1'b0);
		setRow(1, "bothNeg", 9, 24'd100, 9, 24'd100, 1'b0, 8'd0, 8'd0, 1'b1, 1'b0);
		setRow(2, "sat0", 14, 24'd200, 14, 24'd200, 1'b0, 8'd255, 8'd255, 1'b0, 1'b1);
		setRow(3, "mid14", 14, 24'd100, 14, 24'd100, 1'b0, 8'd72, 8'd72, 1'b0, 1'b0);
		setRow(4, "n1Wins", 2, 24'd100, 2, 24'd100, 1'b1, 8'd34, 8'd34, 1'b0, 1'b0);
		setRow(5, "n0Wins", 11, 24'd50, 11, 24'd50, 1'b0, 8'd26, 8'd17, 1'b0, 1'b0);
		setRow(6, "equal", 6, 24'd100, 13, 24'd11, 1'b0, 8'd18, 8'd0, 1'b1, 1'b0);
		setRow(7, "at4096", 12, 24'd4091, 12, 24'd4091, 1'b0, 8'd128, 8'd128, 1'b0, 1'b0);
		setRow(8, "over4096", 12, 24'd4092, 12, 24'd4092, 1'b0, 8'd255, 8'd255, 1'b0, 1'b1);
		setRow(9, "n1Again", 2, 24'd150, 2, 24'd150, 1'b1, 8'd51, 8'd51, 1'b0, 1'b0);
		setRow(10, "zerosAgain", 0, 24'd0, 0, 24'd0, 1'b0, 8'd0, 8'd0, 1'b1, 1'b0);

		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < rowCount; r++)
		begin
			features   = rowFeatures[r];
			testName   = rowName[r];
			tableExp   = rowExp[r];
			tableValid = 1'b1;
			@(posedge clk);
			#1;
		end

		// Back to back, so four vectors are always in flight
		for (int n = 0; n < randomCount; n++)
		begin
			driveRandom(n);
			@(posedge clk);
			#1;
		end

		features   = '0;
		testName   = "drain";
		tableValid = 1'b0;
		repeat (latency) @(posedge clk);
		@(negedge clk);
		#1;

		$display("Closing report: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

	initial
	begin
		#((rowCount + randomCount + 10) * 100);
		$display("The run timed out before all vectors had passed through the DUT");
		$display("Closing report: %0d checks, %0d errors", checkCount, errorCount);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
logic/neuralPkg.sv
logic/neuronResultIf.sv
logic/neuronCore.sv
logic/classDecider.sv
logic/hiddenPairTop.sv
tb/hiddenPairChecker.sv
tb/hiddenPairTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the result

cd "$(dirname "$0")" || exit 1

buildDir="obj_dir"
simBinary="hiddenPairSim"
logFile="sim.log"

verilator --binary --timing --assert \
	-f src.f \
	--top-module hiddenPairTb \
	-Mdir "$buildDir" \
	-o "$simBinary"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Verification passed$" "$logFile"; then
	exit 0
fi

echo "Pass message not found in $logFile"
exit 1
